// File: mister_shell.f
hw/mister_cfg_pkg.sv
hw/ddr_req_if.sv
hw/status_decode.sv
hw/sync_resync.sv
hw/ddr_port_mux.sv
hw/mister_shell.sv
verif/mister_shell_sva.sv
verif/mister_shell_tb.sv

// File: verif/mister_shell_tb.sv
// Testbench for the MiSTer shell with ROTATE_MENU left at 1.
// Inputs change on the rising edge, outputs are sampled on the falling edge.
// pxl_cen runs every other cycle during the sync tests.

`timescale 1ns/1ns

module mister_shell_tb;

    localparam int LINE_CYCLES = 80;
    localparam int TABLE_SUM   = 8 + 8 + 8 + 4 + 3 + 12;
    localparam int LIMIT       = 2 * TABLE_SUM * LINE_CYCLES;

    logic clk_sys, rst_n, vertical_game, rotate, direct_video;
    logic pxl_cen, hs, vs, ld_rd, rot_rd, rot_we, downloading, ddr_busy;
    logic ld_busy, rot_busy, ddr_rd, ddr_we, hsize_en, shadowmask_2x;
    logic shadowmask_rot, db15_en, fb_flip, hs_out, vs_out;
    mister_cfg_pkg::status_t    status;
    mister_cfg_pkg::ddr_addr_t  ld_addr, rot_addr, ddr_addr;
    mister_cfg_pkg::ddr_burst_t ld_burstcnt, rot_burstcnt, ddr_burstcnt;
    mister_cfg_pkg::ddr_be_t    rot_be, ddr_be;
    mister_cfg_pkg::offset_t    hoffset, voffset;
    mister_cfg_pkg::hscale_t    hscale;
    mister_cfg_pkg::shmask_t    shadowmask;
    mister_cfg_pkg::menumask_t  menumask;
    mister_cfg_pkg::ddr_owner_e exp_owner;

    integer seed = 32'hf8f8_3f2e;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int cycles = 0;

    mister_cfg_pkg::status_t status_tab [8];
    // vertical_game, direct_video, shadowmask select, scale enable
    logic [5:0] mask_tab [8] = '{6'b000000, 6'b100001, 6'b010010, 6'b110111,
                                 6'b001000, 6'b101101, 6'b011011, 6'b111100};
    // vertical_game, rotate, toggle bit, expected shadowmask_rot
    logic [3:0] rot_tab [8] = '{4'b0000, 4'b0011, 4'b0100, 4'b0111,
                                4'b1000, 4'b1011, 4'b1101, 4'b1110};
    mister_cfg_pkg::offset_t hofs_tab [4] = '{4'd0, 4'd3, 4'd9, 4'd15};
    mister_cfg_pkg::offset_t vofs_tab [3] = '{4'd0, 4'd5, 4'd15};
    // downloading, ddr_busy, ld_rd, rot_rd, rot_we
    logic [4:0] ddr_tab [12] = '{5'b00010, 5'b01010, 5'b11100, 5'b11100,
                                 5'b10100, 5'b10101, 5'b11111, 5'b01011,
                                 5'b01001, 5'b00001, 5'b00011, 5'b00000};

    mister_shell dut0 (.*);

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: the run went past %0d clock cycles", LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_offset(input string name, input mister_cfg_pkg::offset_t got,
                                input mister_cfg_pkg::offset_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_hscale(input string name, input mister_cfg_pkg::hscale_t got,
                                input mister_cfg_pkg::hscale_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_shmask(input string name, input mister_cfg_pkg::shmask_t got,
                                input mister_cfg_pkg::shmask_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_mask(input string name, input mister_cfg_pkg::menumask_t got,
                              input mister_cfg_pkg::menumask_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input mister_cfg_pkg::ddr_addr_t got,
                              input mister_cfg_pkg::ddr_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_burst(input string name, input mister_cfg_pkg::ddr_burst_t got,
                               input mister_cfg_pkg::ddr_burst_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_be(input string name, input mister_cfg_pkg::ddr_be_t got,
                            input mister_cfg_pkg::ddr_be_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("Test %s finished with %0d errors", name, errors - errs_before);
    endtask

    // Status word carrying only the two sync offsets
    function automatic mister_cfg_pkg::status_t offsets_word(input mister_cfg_pkg::offset_t h,
                                                             input mister_cfg_pkg::offset_t v);
        mister_cfg_pkg::status_t w;
        w = '0;
        w[mister_cfg_pkg::ST_HOFS_LO +: 4] = h;
        w[mister_cfg_pkg::ST_VOFS_LO +: 4] = v;
        return w;
    endfunction

    // Menu mask for ROTATE_MENU at 1
    function automatic mister_cfg_pkg::menumask_t expected_mask(input logic vg, input logic dv,
                                                                input logic [2:0] sh,
                                                                input logic hen);
        mister_cfg_pkg::menumask_t m;
        m = 16'hffff;
        m[4] = ~vg;
        m[3] = (sh == 3'd0);
        m[2] = ~hen;
        m[0] = dv;
        return m;
    endfunction

    task automatic apply_decode(input mister_cfg_pkg::status_t w, input logic vg,
                                input logic rt, input logic dv);
        @(posedge clk_sys);
        status <= w;
        vertical_game <= vg;
        rotate <= rt;
        direct_video <= dv;
        @(posedge clk_sys);
        @(negedge clk_sys);
    endtask

    task automatic video_step(input logic pcen, input logic h, input logic v);
        @(posedge clk_sys);
        pxl_cen <= pcen;
        hs <= h;
        vs <= v;
        @(negedge clk_sys);
    endtask

    task automatic ddr_step(input logic [4:0] s);
        @(posedge clk_sys);
        // Owner model updates on the same edge as the DUT register
        if (!ddr_busy) begin
            exp_owner = downloading ? mister_cfg_pkg::OWN_LOAD : mister_cfg_pkg::OWN_ROT;
        end
        downloading <= s[4];
        ddr_busy <= s[3];
        ld_rd <= s[2];
        rot_rd <= s[1];
        rot_we <= s[0];
        ld_addr <= mister_cfg_pkg::ddr_addr_t'($random(seed));
        ld_burstcnt <= mister_cfg_pkg::ddr_burst_t'($random(seed));
        rot_addr <= mister_cfg_pkg::ddr_addr_t'($random(seed));
        rot_burstcnt <= mister_cfg_pkg::ddr_burst_t'($random(seed));
        rot_be <= mister_cfg_pkg::ddr_be_t'($random(seed));
        @(negedge clk_sys);
        if (exp_owner == mister_cfg_pkg::OWN_LOAD) begin
            check_addr("ddr_addr", ddr_addr, ld_addr);
            check_burst("ddr_burstcnt", ddr_burstcnt, ld_burstcnt);
            // Loader reads whole words
            check_be("ddr_be", ddr_be, 8'hff);
            check_bit("ddr_rd", ddr_rd, ld_rd);
            check_bit("ddr_we", ddr_we, 1'b0);
            check_bit("ld_busy", ld_busy, ddr_busy);
            check_bit("rot_busy", rot_busy, 1'b1);
        end else begin
            check_addr("ddr_addr", ddr_addr, rot_addr);
            check_burst("ddr_burstcnt", ddr_burstcnt, rot_burstcnt);
            check_be("ddr_be", ddr_be, rot_be);
            check_bit("ddr_rd", ddr_rd, rot_rd);
            check_bit("ddr_we", ddr_we, rot_we);
            check_bit("ld_busy", ld_busy, 1'b1);
            check_bit("rot_busy", rot_busy, ddr_busy);
        end
    endtask

    initial begin
        int eb;
        int count;
        logic prev_tick;
        logic seen;
        mister_cfg_pkg::status_t w;

        rst_n = 1'b0;
        status = '0;
        vertical_game = 1'b0;
        rotate = 1'b0;
        direct_video = 1'b0;
        pxl_cen = 1'b0;
        hs = 1'b0;
        vs = 1'b0;
        ld_addr = '0;
        ld_burstcnt = 8'd4;
        ld_rd = 1'b0;
        rot_addr = '0;
        rot_burstcnt = 8'd1;
        rot_be = 8'hff;
        rot_rd = 1'b0;
        rot_we = 1'b0;
        downloading = 1'b0;
        ddr_busy = 1'b0;
        exp_owner = mister_cfg_pkg::OWN_ROT;
        for (int i = 0; i < 8; i++) begin
            status_tab[i] = {$random(seed), $random(seed)};
        end

        repeat (4) @(posedge clk_sys);
        rst_n <= 1'b1;
        @(negedge clk_sys);

        // Reset values and shadowmask rotation
        eb = errors;
        check_offset("hoffset", hoffset, '0);
        check_offset("voffset", voffset, '0);
        check_hscale("hscale", hscale, '0);
        check_shmask("shadowmask", shadowmask, '0);
        check_bit("hsize_en", hsize_en, 1'b0);
        check_bit("shadowmask_2x", shadowmask_2x, 1'b0);
        check_bit("shadowmask_rot", shadowmask_rot, 1'b0);
        check_bit("db15_en", db15_en, 1'b0);
        check_bit("fb_flip", fb_flip, 1'b0);
        check_bit("hs_out", hs_out, 1'b0);
        check_bit("vs_out", vs_out, 1'b0);
        check_bit("ddr_rd", ddr_rd, 1'b0);
        check_bit("ddr_we", ddr_we, 1'b0);
        check_mask("menumask", menumask, 16'hffff);
        for (int i = 0; i < 8; i++) begin
            w = '0;
            w[mister_cfg_pkg::ST_SHMASK_ROT] = rot_tab[i][1];
            apply_decode(w, rot_tab[i][3], rot_tab[i][2], 1'b0);
            check_bit("shadowmask_rot", shadowmask_rot, rot_tab[i][0]);
        end
        report_test("reset and shadowmask rotation", eb);

        eb = errors;
        for (int i = 0; i < 8; i++) begin
            w = status_tab[i];
            apply_decode(w, 1'b0, 1'b0, 1'b0);
            check_offset("hoffset", hoffset, w[27:24]);
            check_offset("voffset", voffset, w[31:28]);
            check_bit("hsize_en", hsize_en, w[19]);
            check_hscale("hscale", hscale, w[23:20]);
            check_shmask("shadowmask", shadowmask, w[34:32]);
            check_bit("shadowmask_2x", shadowmask_2x, w[35]);
            check_bit("db15_en", db15_en, w[37]);
            check_bit("fb_flip", fb_flip, w[39:38] == 2'd2);
        end
        report_test("status decode", eb);

        eb = errors;
        for (int i = 0; i < 8; i++) begin
            w = '0;
            w[34:32] = mask_tab[i][3:1];
            w[19] = mask_tab[i][0];
            apply_decode(w, mask_tab[i][5], 1'b0, mask_tab[i][4]);
            check_mask("menumask", menumask, expected_mask(mask_tab[i][5], mask_tab[i][4],
                                                           mask_tab[i][3:1], mask_tab[i][0]));
        end
        report_test("menu mask", eb);

        eb = errors;
        for (int i = 0; i < 4; i++) begin
            apply_decode(offsets_word(hofs_tab[i], 4'd0), 1'b0, 1'b0, 1'b0);
            repeat (20) begin
                video_step(1'b1, 1'b0, 1'b0);
                video_step(1'b0, 1'b0, 1'b0);
            end
            count = 0;
            prev_tick = 1'b0;
            seen = 1'b0;
            for (int c = 0; c < 40 && !seen; c++) begin
                video_step(c % 2 == 0, 1'b1, 1'b0);
                count += prev_tick;
                prev_tick = pxl_cen & hs;
                seen = hs_out;
            end
            if (!seen) begin
                errors++;
                $display("hs_out never rose for hoffset %0d", hofs_tab[i]);
            end
            check_count("hs_out delay", count, hofs_tab[i] + 1);
        end
        report_test("horizontal delay", eb);

        eb = errors;
        for (int i = 0; i < 3; i++) begin
            apply_decode(offsets_word(4'd0, vofs_tab[i]), 1'b0, 1'b0, 1'b0);
            for (int ln = 0; ln < 18; ln++) begin
                for (int c = 0; c < 8; c++) begin
                    video_step(c % 2 == 0, c < 4, 1'b0);
                end
            end
            count = 0;
            seen = 1'b0;
            for (int ln = 0; ln < 20 && !seen; ln++) begin
                for (int c = 0; c < 8 && !seen; c++) begin
                    video_step(c % 2 == 0, c < 4, 1'b1);
                    // The line start was sampled on this step's edge
                    if (c == 1) begin
                        count++;
                    end
                    seen = vs_out;
                end
            end
            if (!seen) begin
                errors++;
                $display("vs_out never rose for voffset %0d", vofs_tab[i]);
            end
            check_count("vs_out delay", count, vofs_tab[i] + 1);
        end
        report_test("vertical delay", eb);

        eb = errors;
        for (int i = 0; i < 12; i++) begin
            ddr_step(ddr_tab[i]);
        end
        report_test("DDR handover", eb);

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: verif/mister_shell_sva.sv
// Assertions on the DDR port multiplexer, bound into every ddr_port_mux.
// They watch the owner register and both client busy levels.

`timescale 1ns/1ns

module mister_shell_sva (
    input logic                       clk_sys,
    input logic                       rst_n,
    input logic                       ddr_busy,
    input mister_cfg_pkg::ddr_owner_e owner,
    input logic                       ld_busy,
    input logic                       rot_busy,
    input logic                       rot_rd,
    input logic                       rot_we,
    input logic                       ddr_rd,
    input logic                       ddr_we
);

    // The client that does not own DDR is always held off
    idle_busy_high: assert property (@(posedge clk_sys) disable iff (!rst_n)
        (owner == mister_cfg_pkg::OWN_LOAD) ? rot_busy : ld_busy)
        else $error("idle client busy is low");

    owner_holds: assert property (@(posedge clk_sys) disable iff (!rst_n)
        ddr_busy |=> $stable(owner))
        else $error("owner changed while ddr_busy was high");

    quiet_after_reset: assert property (@(posedge clk_sys)
        ($rose(rst_n) && !rot_rd && !rot_we) |-> (!ddr_rd && !ddr_we))
        else $error("DDR request active right after reset");

endmodule

bind ddr_port_mux mister_shell_sva u_sva (
    .clk_sys  ( clk_sys  ),
    .rst_n    ( rst_n    ),
    .ddr_busy ( ddr_busy ),
    .owner    ( owner    ),
    .ld_busy  ( ld.busy  ),
    .rot_busy ( rot.busy ),
    .rot_rd   ( rot.rd   ),
    .rot_we   ( rot.we   ),
    .ddr_rd   ( ddr_rd   ),
    .ddr_we   ( ddr_we   )
);

// File: hw/mister_shell.sv
// Glue between the MiSTer framework and a game core.
// Single clock domain on clk_sys; rst_n is asynchronous.
// The loader only reads from DDR, so its byte enables are all set and it
// never writes. DDR data buses run outside this block.

`timescale 1ns/1ns

module mister_shell #(
    parameter bit ROTATE_MENU = 1'b1
) (
    // Control
    input  logic                       clk_sys,
    input  logic                       rst_n,
    input  mister_cfg_pkg::status_t    status,
    input  logic                       vertical_game,
    input  logic                       rotate,
    input  logic                       direct_video,
    // Video
    input  logic                       pxl_cen,
    input  logic                       hs,
    input  logic                       vs,
    // Loader request
    input  mister_cfg_pkg::ddr_addr_t  ld_addr,
    input  mister_cfg_pkg::ddr_burst_t ld_burstcnt,
    input  logic                       ld_rd,
    output logic                       ld_busy,
    // Rotation request
    input  mister_cfg_pkg::ddr_addr_t  rot_addr,
    input  mister_cfg_pkg::ddr_burst_t rot_burstcnt,
    input  mister_cfg_pkg::ddr_be_t    rot_be,
    input  logic                       rot_rd,
    input  logic                       rot_we,
    output logic                       rot_busy,
    // DDR
    input  logic                       downloading,
    input  logic                       ddr_busy,
    output mister_cfg_pkg::ddr_addr_t  ddr_addr,
    output mister_cfg_pkg::ddr_burst_t ddr_burstcnt,
    output mister_cfg_pkg::ddr_be_t    ddr_be,
    output logic                       ddr_rd,
    output logic                       ddr_we,
    // Decoded settings
    output mister_cfg_pkg::offset_t    hoffset,
    output mister_cfg_pkg::offset_t    voffset,
    output logic                       hsize_en,
    output mister_cfg_pkg::hscale_t    hscale,
    output mister_cfg_pkg::shmask_t    shadowmask,
    output logic                       shadowmask_2x,
    output logic                       shadowmask_rot,
    output logic                       db15_en,
    output logic                       fb_flip,
    output mister_cfg_pkg::menumask_t  menumask,
    // Re-timed sync
    output logic                       hs_out,
    output logic                       vs_out
);

    ddr_req_if ld_req ();
    ddr_req_if rot_req ();

    // Loader is read only
    assign ld_req.addr     = ld_addr;
    assign ld_req.burstcnt = ld_burstcnt;
    assign ld_req.be       = '1;
    assign ld_req.rd       = ld_rd;
    assign ld_req.we       = 1'b0;
    assign ld_busy         = ld_req.busy;

    assign rot_req.addr     = rot_addr;
    assign rot_req.burstcnt = rot_burstcnt;
    assign rot_req.be       = rot_be;
    assign rot_req.rd       = rot_rd;
    assign rot_req.we       = rot_we;
    assign rot_busy         = rot_req.busy;

    status_decode #(
        .ROTATE_MENU    ( ROTATE_MENU    )
    ) u_status (
        .clk_sys        ( clk_sys        ),
        .rst_n          ( rst_n          ),
        .status         ( status         ),
        .vertical_game  ( vertical_game  ),
        .rotate         ( rotate         ),
        .direct_video   ( direct_video   ),
        .hoffset        ( hoffset        ),
        .voffset        ( voffset        ),
        .hsize_en       ( hsize_en       ),
        .hscale         ( hscale         ),
        .shadowmask     ( shadowmask     ),
        .shadowmask_2x  ( shadowmask_2x  ),
        .shadowmask_rot ( shadowmask_rot ),
        .db15_en        ( db15_en        ),
        .fb_flip        ( fb_flip        ),
        .menumask       ( menumask       )
    );

    // Offsets come from the registered decode
    sync_resync u_resync (
        .clk_sys ( clk_sys ),
        .rst_n   ( rst_n   ),
        .pxl_cen ( pxl_cen ),
        .hs      ( hs      ),
        .vs      ( vs      ),
        .hoffset ( hoffset ),
        .voffset ( voffset ),
        .hs_out  ( hs_out  ),
        .vs_out  ( vs_out  )
    );

    ddr_port_mux u_ddrmux (
        .clk_sys      ( clk_sys      ),
        .rst_n        ( rst_n        ),
        .downloading  ( downloading  ),
        .ld           ( ld_req       ),
        .rot          ( rot_req      ),
        .ddr_busy     ( ddr_busy     ),
        .ddr_addr     ( ddr_addr     ),
        .ddr_burstcnt ( ddr_burstcnt ),
        .ddr_be       ( ddr_be       ),
        .ddr_rd       ( ddr_rd       ),
        .ddr_we       ( ddr_we       )
    );

endmodule

// File: hw/ddr_port_mux.sv
// Shares the single DDR request port between the ROM loader and the
// screen-rotation client.
// The loader owns DDR while downloading is high, the rotation client otherwise.
// Ownership only moves while DDR is idle, so a burst is never split.
// The idle client sees busy stuck high and must hold its request.

`timescale 1ns/1ns

module ddr_port_mux (
    input  logic                       clk_sys,
    input  logic                       rst_n,
    input  logic                       downloading,
    ddr_req_if.arbiter                 ld,
    ddr_req_if.arbiter                 rot,
    input  logic                       ddr_busy,
    output mister_cfg_pkg::ddr_addr_t  ddr_addr,
    output mister_cfg_pkg::ddr_burst_t ddr_burstcnt,
    output mister_cfg_pkg::ddr_be_t    ddr_be,
    output logic                       ddr_rd,
    output logic                       ddr_we
);

    mister_cfg_pkg::ddr_owner_e owner;
    mister_cfg_pkg::ddr_owner_e owner_nxt;

    assign owner_nxt = downloading ? mister_cfg_pkg::OWN_LOAD : mister_cfg_pkg::OWN_ROT;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            owner <= mister_cfg_pkg::OWN_ROT;
        end else if (!ddr_busy) begin
            owner <= owner_nxt;
        end
    end

    // Steer the owner's request to DDR
    always_comb begin
        if (owner == mister_cfg_pkg::OWN_LOAD) begin
            ddr_addr     = ld.addr;
            ddr_burstcnt = ld.burstcnt;
            ddr_be       = ld.be;
            ddr_rd       = ld.rd;
            ddr_we       = ld.we;
        end else begin
            ddr_addr     = rot.addr;
            ddr_burstcnt = rot.burstcnt;
            ddr_be       = rot.be;
            ddr_rd       = rot.rd;
            ddr_we       = rot.we;
        end
    end

    // Only the owner sees the real busy level
    assign ld.busy  = (owner == mister_cfg_pkg::OWN_LOAD) ? ddr_busy : 1'b1;
    assign rot.busy = (owner == mister_cfg_pkg::OWN_ROT)  ? ddr_busy : 1'b1;

endmodule

// File: hw/sync_resync.sv
// Moves the game sync pulses against blanking to centre the picture on a CRT.
// hs is delayed by hoffset pixels and vs by voffset lines, 0 to 15 each.
// Histories only advance on pxl_cen; the selected stage is re-registered
// every clk_sys edge, so an offset change shows up one cycle later.
// Blanking is not touched here.

`timescale 1ns/1ns

module sync_resync (
    input  logic                    clk_sys,
    input  logic                    rst_n,
    input  logic                    pxl_cen,
    input  logic                    hs,
    input  logic                    vs,
    input  mister_cfg_pkg::offset_t hoffset,
    input  mister_cfg_pkg::offset_t voffset,
    output logic                    hs_out,
    output logic                    vs_out
);

    localparam int DEPTH = 2 ** mister_cfg_pkg::OFFSET_W;

    logic [DEPTH-1:0] hs_hist;
    logic [DEPTH-1:0] vs_hist;
    logic             hs_rise;

    // Stage 0 holds the previous pxl_cen sample of hs
    assign hs_rise = pxl_cen & hs & ~hs_hist[0];

    // One stage per pixel
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            hs_hist <= '0;
        end else if (pxl_cen) begin
            hs_hist <= {hs_hist[DEPTH-2:0], hs};
        end
    end

    // One stage per line, clocked by the start of each hs pulse
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            vs_hist <= '0;
        end else if (hs_rise) begin
            vs_hist <= {vs_hist[DEPTH-2:0], vs};
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            hs_out <= 1'b0;
            vs_out <= 1'b0;
        end else begin
            hs_out <= hs_hist[hoffset];
            vs_out <= vs_hist[voffset];
        end
    end

endmodule

// File: hw/status_decode.sv
// Registered decode of the menu status word.
// All outputs lag their inputs by exactly one clk_sys cycle.
// Out of reset every item of the menu is hidden until the first decode.
// ROTATE_MENU picks menu item 4 (set) or item 1 (clear) for the rotate option.

`timescale 1ns/1ns

module status_decode #(
    parameter bit ROTATE_MENU = 1'b1
) (
    input  logic                       clk_sys,
    input  logic                       rst_n,
    input  mister_cfg_pkg::status_t    status,
    input  logic                       vertical_game,
    input  logic                       rotate,
    input  logic                       direct_video,
    output mister_cfg_pkg::offset_t    hoffset,
    output mister_cfg_pkg::offset_t    voffset,
    output logic                       hsize_en,
    output mister_cfg_pkg::hscale_t    hscale,
    output mister_cfg_pkg::shmask_t    shadowmask,
    output logic                       shadowmask_2x,
    output logic                       shadowmask_rot,
    output logic                       db15_en,
    output logic                       fb_flip,
    output mister_cfg_pkg::menumask_t  menumask
);

    mister_cfg_pkg::shmask_t   shmask_sel;
    mister_cfg_pkg::menumask_t mask_nxt;

    assign shmask_sel = status[mister_cfg_pkg::ST_SHMASK_LO +: mister_cfg_pkg::SHMASK_W];

    // Items that make no sense for the current setup are hidden
    always_comb begin
        mask_nxt    = '1;
        mask_nxt[3] = shmask_sel == '0;
        mask_nxt[2] = ~status[mister_cfg_pkg::ST_HSIZE_EN];
        mask_nxt[0] = direct_video;
        if (ROTATE_MENU) begin
            mask_nxt[4] = ~vertical_game;
            mask_nxt[1] = 1'b1;
        end else begin
            mask_nxt[4] = 1'b1;
            mask_nxt[1] = ~vertical_game;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            hoffset        <= '0;
            voffset        <= '0;
            hsize_en       <= 1'b0;
            hscale         <= '0;
            shadowmask     <= '0;
            shadowmask_2x  <= 1'b0;
            shadowmask_rot <= 1'b0;
            db15_en        <= 1'b0;
            fb_flip        <= 1'b0;
            menumask       <= '1;
        end else begin
            hoffset       <= status[mister_cfg_pkg::ST_HOFS_LO +: mister_cfg_pkg::OFFSET_W];
            voffset       <= status[mister_cfg_pkg::ST_VOFS_LO +: mister_cfg_pkg::OFFSET_W];
            hsize_en      <= status[mister_cfg_pkg::ST_HSIZE_EN];
            hscale        <= status[mister_cfg_pkg::ST_HSCALE_LO +: mister_cfg_pkg::HSCALE_W];
            shadowmask    <= shmask_sel;
            shadowmask_2x <= status[mister_cfg_pkg::ST_SHMASK_2X];
            // A rotated vertical game turns the mask pattern by itself
            shadowmask_rot <= status[mister_cfg_pkg::ST_SHMASK_ROT] ^ (vertical_game & rotate);
            db15_en       <= status[mister_cfg_pkg::ST_DB15];
            fb_flip       <= status[mister_cfg_pkg::ST_FLIP_LO +: mister_cfg_pkg::FLIP_W]
                             == mister_cfg_pkg::FLIP_CODE;
            menumask      <= mask_nxt;
        end
    end

endmodule

// File: hw/ddr_req_if.sv
// One DDR request port as seen by a client and by the port arbiter.
// The data buses are not part of the bundle.
// A client may change its request only while busy is low.

`timescale 1ns/1ns

interface ddr_req_if;

    mister_cfg_pkg::ddr_addr_t  addr;
    mister_cfg_pkg::ddr_burst_t burstcnt;
    mister_cfg_pkg::ddr_be_t    be;
    logic                       rd;
    logic                       we;
    // Held high by the arbiter when the client does not own DDR
    logic                       busy;

    modport client (
        output addr,
        output burstcnt,
        output be,
        output rd,
        output we,
        input  busy
    );

    modport arbiter (
        input  addr,
        input  burstcnt,
        input  be,
        input  rd,
        input  we,
        output busy
    );

endinterface

// File: hw/mister_cfg_pkg.sv
// Shared widths, status-word bit positions and types for the MiSTer shell.
// Bit positions follow the on-screen-menu layout of the framework status word.
// Every field is addressed as LO position plus its width.

package mister_cfg_pkg;

    // Field widths
    localparam int STATUS_W    = 64;
    localparam int OFFSET_W    = 4;
    localparam int HSCALE_W    = 4;
    localparam int SHMASK_W    = 3;
    localparam int FLIP_W      = 2;
    localparam int MENUMASK_W  = 16;
    localparam int DDR_ADDR_W  = 29;
    localparam int DDR_BURST_W = 8;
    localparam int DDR_BE_W    = 8;

    // Status word bit positions
    localparam int ST_HSIZE_EN   = 19;
    localparam int ST_HSCALE_LO  = 20;
    localparam int ST_HOFS_LO    = 24;
    localparam int ST_VOFS_LO    = 28;
    localparam int ST_SHMASK_LO  = 32;
    localparam int ST_SHMASK_2X  = 35;
    localparam int ST_SHMASK_ROT = 36;
    localparam int ST_DB15       = 37;
    localparam int ST_FLIP_LO    = 38;

    // Flip field value that turns the framebuffer upside down
    localparam logic [FLIP_W-1:0] FLIP_CODE = 2'd2;

    // Menu word from the HPS
    typedef logic [STATUS_W-1:0] status_t;

    // Sync offset in pixels or lines, 0 to 15
    typedef logic [OFFSET_W-1:0] offset_t;

    typedef logic [HSCALE_W-1:0] hscale_t;

    // Shadowmask pattern, zero means off
    typedef logic [SHMASK_W-1:0] shmask_t;

    // A set bit hides the menu item
    typedef logic [MENUMASK_W-1:0] menumask_t;

    // DDR request fields
    typedef logic [DDR_ADDR_W-1:0]  ddr_addr_t;
    typedef logic [DDR_BURST_W-1:0] ddr_burst_t;
    typedef logic [DDR_BE_W-1:0]    ddr_be_t;

    // Which client owns the DDR port
    typedef enum logic {
        OWN_LOAD,
        OWN_ROT
    } ddr_owner_e;

endpackage
